//--- hw/lsuBus_params.svh
// Size parameters for the load/store bus interface.
// Include this header wherever a word, address or line width is needed.
// The package builds all of its vector types from these values.

`ifndef LSU_BUS_PARAMS_SVH
`define LSU_BUS_PARAMS_SVH

// Data word width in bits
`define LSU_XLEN 32

// Physical address width in bits
`define LSU_PALEN 32

// Cache line geometry, LSU_LOG_WPL must equal log2 of LSU_WORDS_PER_LINE
`define LSU_WORDS_PER_LINE 4
`define LSU_LOG_WPL 2

`endif

//--- hw/lsuBusPkg.sv
// Shared types for the load/store bus interface.
// Modules import this package inside their body and use scoped names on ports.
// Bus encodings follow the AHB-Lite transfer and burst fields.

`include "lsuBus_params.svh"

package lsuBusPkg;

  ///////////////////////////////
  // Vector types
  ///////////////////////////////
  typedef logic [`LSU_XLEN-1:0] wordT;
  typedef logic [`LSU_PALEN-1:0] adrT;
  typedef logic [`LSU_LOG_WPL-1:0] beatT;
  typedef logic [`LSU_WORDS_PER_LINE*`LSU_XLEN-1:0] lineT;

  // Transfer type on the bus, BUSY is never issued
  typedef logic [1:0] transT;
  localparam transT transIdle = 2'b00;
  localparam transT transNonseq = 2'b10;
  localparam transT transSeq = 2'b11;

  // Burst type on the bus
  typedef logic [2:0] burstT;
  localparam burstT burstSingle = 3'b000;
  localparam burstT burstIncr = 3'b001;
  localparam burstT burstIncr4 = 3'b011;
  localparam burstT burstIncr8 = 3'b101;
  localparam burstT burstIncr16 = 3'b111;

  ///////////////////////////////
  // Bus state machine
  ///////////////////////////////
  typedef enum logic [2:0] {
    stateReady,
    stateFetch,
    stateWrite,
    stateUncachedWrite,
    stateUncachedWriteDone,
    stateUncachedRead,
    stateUncachedReadDone,
    stateCpuBusy
  } busStateT;

  ///////////////////////////////
  // Grouped signals
  ///////////////////////////////
  // Processor request, readWrite bit 1 asks for a read and bit 0 for a write
  typedef struct packed {
    logic [1:0] readWrite;
    adrT adr;
    wordT wdata;
    logic cacheable;
  } cpuReqT;

  // Everything the slave samples in an address phase
  typedef struct packed {
    adrT adr;
    transT trans;
    burstT burst;
    logic write;
  } busCmdT;

endpackage

//--- hw/busFsm.sv
// Bus sequencer of the load/store unit.
// Runs single uncached reads and writes for the processor and line bursts
// for the data cache, one transfer at a time. busAck is the bus ready signal.
// wordCount follows the address phase and wordCountDelayed the data phase.

`timescale 1ns/10ps
`include "lsuBus_params.svh"

module busFsm (
  input  logic clk,
  input  logic reset,
  input  logic ignoreRequest,
  input  logic [1:0] readWrite,
  input  logic cacheable,
  input  logic fetchLine,
  input  logic writeLine,
  input  logic busAck,
  input  logic cpuBusy,
  output logic stall,
  output logic committed,
  output logic busRead,
  output logic busWrite,
  output logic selUncachedAdr,
  output logic transComplete,
  output logic cacheBusAck,
  output lsuBusPkg::transT trans,
  output lsuBusPkg::burstT burst,
  output lsuBusPkg::beatT wordCount,
  output lsuBusPkg::beatT wordCountDelayed
);

  import lsuBusPkg::*;

  // Index of the final word of a line
  localparam beatT lastIdx = beatT'(`LSU_WORDS_PER_LINE - 1);

  // Burst length follows the line size
  localparam burstT lineBurst = (`LSU_WORDS_PER_LINE == 4) ? burstIncr4 :
                                (`LSU_WORDS_PER_LINE == 8) ? burstIncr8 :
                                (`LSU_WORDS_PER_LINE == 16) ? burstIncr16 : burstIncr;

  busStateT state;
  busStateT nextState;
  logic uncachedAccess;
  logic lineState;
  logic uncachedState;
  logic lastBeat;
  logic adrPhaseDone;
  logic cntEn;
  logic cntClear;

  ///////////////////////////////
  // State register
  ///////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= stateReady;
    end else begin
      state <= nextState;
    end
  end

  // Only non-cacheable processor accesses go straight to the bus
  assign uncachedAccess = ~cacheable;

  // In ready the uncached write wins, then uncached read, then line fetch and writeback
  always_comb begin
    nextState = state;
    case (state)
      stateReady: begin
        if (ignoreRequest) begin
          nextState = stateReady;
        end else if (readWrite[0] & uncachedAccess) begin
          nextState = stateUncachedWrite;
        end else if (readWrite[1] & uncachedAccess) begin
          nextState = stateUncachedRead;
        end else if (fetchLine) begin
          nextState = stateFetch;
        end else if (writeLine) begin
          nextState = stateWrite;
        end
      end
      stateUncachedWrite: begin
        if (transComplete) begin
          nextState = stateUncachedWriteDone;
        end
      end
      stateUncachedRead: begin
        if (transComplete) begin
          nextState = stateUncachedReadDone;
        end
      end
      // The processor may still be busy elsewhere, so keep the bus committed
      stateUncachedWriteDone, stateUncachedReadDone, stateCpuBusy: begin
        nextState = cpuBusy ? stateCpuBusy : stateReady;
      end
      stateFetch, stateWrite: begin
        if (transComplete) begin
          nextState = stateReady;
        end
      end
      default: nextState = stateReady;
    endcase
  end

  assign lineState = (state == stateFetch) | (state == stateWrite);
  assign uncachedState = (state == stateUncachedRead) | (state == stateUncachedWrite);

  ///////////////////////////////
  // Beat counters
  ///////////////////////////////
  // Once the data counter sits on the last word every address has been accepted
  assign lastBeat = (wordCountDelayed == lastIdx);

  // A single access has one address phase and a nonzero count marks it as taken
  assign adrPhaseDone = |wordCount;

  // Count each accepted address phase and freeze the counters while busAck is low
  assign cntEn = busAck & ((lineState & ~lastBeat) | (uncachedState & ~adrPhaseDone));
  assign cntClear = transComplete;

  always_ff @(posedge clk) begin
    if (reset | cntClear) begin
      wordCount <= '0;
      wordCountDelayed <= '0;
    end else if (cntEn) begin
      // The address counter parks on the last word while the final data phase runs
      wordCount <= (wordCount == lastIdx) ? wordCount : wordCount + beatT'(1);
      wordCountDelayed <= wordCount;
    end
  end

  ///////////////////////////////
  // Bus controls
  ///////////////////////////////
  assign burst = lineState ? lineBurst : burstSingle;

  // First beat is NONSEQ, later beats SEQ, and IDLE once only data is left
  always_comb begin
    if (lineState) begin
      if (lastBeat) begin
        trans = transIdle;
      end else if (wordCount == '0) begin
        trans = transNonseq;
      end else begin
        trans = transSeq;
      end
    end else if (uncachedState) begin
      trans = adrPhaseDone ? transIdle : transNonseq;
    end else begin
      trans = transIdle;
    end
  end

  // A transfer ends when the slave acknowledges its last data phase
  assign transComplete = busAck & ((lineState & lastBeat) | (uncachedState & adrPhaseDone));
  assign cacheBusAck = lineState & transComplete;

  assign busRead = (state == stateFetch) | (state == stateUncachedRead);
  assign busWrite = (state == stateWrite) | (state == stateUncachedWrite);

  // The request address is used from the request cycle until the access retires
  assign selUncachedAdr = ((state == stateReady) & uncachedAccess & (|readWrite)) |
                          (state == stateUncachedRead) |
                          (state == stateUncachedReadDone) |
                          (state == stateUncachedWrite) |
                          (state == stateUncachedWriteDone);

  ///////////////////////////////
  // Processor side
  ///////////////////////////////
  // Stall rises in the request cycle, before the state register moves
  assign stall = ((state == stateReady) & ~ignoreRequest &
                  ((uncachedAccess & (|readWrite)) | fetchLine | writeLine)) |
                 uncachedState | lineState;

  assign committed = (state != stateReady);

endmodule

//--- hw/lineBuffer.sv
// Line staging register between the data cache and the bus.
// Fetched words land here one data phase at a time, and the word for
// each writeback data phase is picked from the cache line.

`timescale 1ns/10ps
`include "lsuBus_params.svh"

module lineBuffer (
  input  logic clk,
  input  logic reset,
  input  logic captureWord,
  input  lsuBusPkg::beatT wordCountDelayed,
  input  lsuBusPkg::wordT busRdData,
  input  lsuBusPkg::lineT lineWrData,
  output lsuBusPkg::lineT lineRdData,
  output lsuBusPkg::wordT wrWord
);

  import lsuBusPkg::*;

  // Per-word write enables of the fetch register
  logic [`LSU_WORDS_PER_LINE-1:0] wordEn;

  ///////////////////////////////
  // Fetch path
  ///////////////////////////////
  // The data counter names the word whose data phase is finishing
  always_comb begin
    for (int i = 0; i < `LSU_WORDS_PER_LINE; i++) begin
      wordEn[i] = captureWord & (wordCountDelayed == beatT'(i));
    end
  end

  // Each word is written once per fetch, the full line is ready after the last beat
  always_ff @(posedge clk) begin
    if (reset) begin
      lineRdData <= '0;
    end else begin
      for (int i = 0; i < `LSU_WORDS_PER_LINE; i++) begin
        if (wordEn[i]) begin
          lineRdData[i*`LSU_XLEN +: `LSU_XLEN] <= busRdData;
        end
      end
    end
  end

  ///////////////////////////////
  // Writeback path
  ///////////////////////////////
  // Write data trails its address by one beat, so the data counter does the select.
  // The cache holds lineWrData steady for the whole burst
  always_comb begin
    wrWord = '0;
    for (int i = 0; i < `LSU_WORDS_PER_LINE; i++) begin
      if (wordCountDelayed == beatT'(i)) begin
        wrWord = lineWrData[i*`LSU_XLEN +: `LSU_XLEN];
      end
    end
  end

endmodule

//--- hw/busAdapter.sv
// Bus-facing data path of the load/store unit.
// Builds the address-phase command, aligns write data to the data phase
// and returns the word of an uncached read to the processor.

`timescale 1ns/10ps
`include "lsuBus_params.svh"

module busAdapter (
  input  logic clk,
  input  logic reset,
  input  lsuBusPkg::cpuReqT req,
  input  lsuBusPkg::adrT lineAdr,
  input  logic selUncachedAdr,
  input  logic busRead,
  input  logic busWrite,
  input  logic selLineWord,
  input  lsuBusPkg::transT trans,
  input  lsuBusPkg::burstT burst,
  input  lsuBusPkg::beatT wordCount,
  input  lsuBusPkg::wordT wrWord,
  input  lsuBusPkg::wordT busRdData,
  input  logic busAck,
  output lsuBusPkg::busCmdT busCmd,
  output lsuBusPkg::wordT busWrData,
  output lsuBusPkg::wordT rdData
);

  import lsuBusPkg::*;

  adrT beatAdr;
  logic dataSrcLine;
  wordT wdataQ;
  wordT rdDataQ;
  logic uncachedRdDone;

  ///////////////////////////////
  // Address phase
  ///////////////////////////////
  // Line beats walk up from the aligned line address one word at a time
  assign beatAdr = lineAdr + adrT'(wordCount) * adrT'(`LSU_XLEN / 8);

  always_comb begin
    busCmd.adr = selUncachedAdr ? req.adr : beatAdr;
    busCmd.trans = trans;
    busCmd.burst = burst;
    busCmd.write = busWrite;
  end

  ///////////////////////////////
  // Data phase
  ///////////////////////////////
  // When an address phase is accepted, remember where its write data comes from
  always_ff @(posedge clk) begin
    if (reset) begin
      dataSrcLine <= 1'b0;
    end else if (busAck) begin
      dataSrcLine <= selLineWord;
    end
  end

  always_ff @(posedge clk) begin
    if (busAck) begin
      wdataQ <= req.wdata;
    end
  end

  // Line words already follow the data counter, so only the select is delayed
  assign busWrData = dataSrcLine ? wrWord : wdataQ;

  // Uncached read data phase ends when ready arrives after the address has gone
  assign uncachedRdDone = busRead & selUncachedAdr & busAck & (trans == transIdle);

  always_ff @(posedge clk) begin
    if (uncachedRdDone) begin
      rdDataQ <= busRdData;
    end
  end

  // Pass the bus word through in the completing cycle and hold it afterwards
  assign rdData = uncachedRdDone ? busRdData : rdDataQ;

endmodule

//--- hw/lsuBus.sv
// Top level of the load/store bus interface.
// Connects the processor request port, the data cache line port and an
// AHB-Lite style master port. The bus ready input also serves as the ack.

`timescale 1ns/10ps

module lsuBus (
  input  logic clk,
  input  logic reset,
  // Processor side
  input  lsuBusPkg::cpuReqT req,
  input  logic ignoreRequest,
  input  logic cpuBusy,
  output logic stall,
  output logic committed,
  output lsuBusPkg::wordT rdData,
  // Data cache side
  input  logic fetchLine,
  input  logic writeLine,
  input  lsuBusPkg::adrT lineAdr,
  input  lsuBusPkg::lineT lineWrData,
  output lsuBusPkg::lineT lineRdData,
  output logic cacheBusAck,
  // Bus side
  output lsuBusPkg::busCmdT busCmd,
  output lsuBusPkg::wordT busWrData,
  input  lsuBusPkg::wordT busRdData,
  input  logic busReady
);

  import lsuBusPkg::*;

  logic busRead;
  logic busWrite;
  logic selUncachedAdr;
  logic selLineWord;
  logic transComplete;
  logic captureWord;
  transT trans;
  burstT burst;
  beatT wordCount;
  beatT wordCountDelayed;
  wordT wrWord;

  // Line writebacks take data from the buffer, uncached writes from the request
  assign selLineWord = busWrite & ~selUncachedAdr;

  // A fetch beat's data phase is running once its first address has been taken
  assign captureWord = busRead & ~selUncachedAdr & busReady & (|wordCount);

  busFsm busFsm_inst (
    .clk(clk),
    .reset(reset),
    .ignoreRequest(ignoreRequest),
    .readWrite(req.readWrite),
    .cacheable(req.cacheable),
    .fetchLine(fetchLine),
    .writeLine(writeLine),
    .busAck(busReady),
    .cpuBusy(cpuBusy),
    .stall(stall),
    .committed(committed),
    .busRead(busRead),
    .busWrite(busWrite),
    .selUncachedAdr(selUncachedAdr),
    .transComplete(transComplete),
    .cacheBusAck(cacheBusAck),
    .trans(trans),
    .burst(burst),
    .wordCount(wordCount),
    .wordCountDelayed(wordCountDelayed)
  );

  lineBuffer lineBuffer_inst (
    .clk(clk),
    .reset(reset),
    .captureWord(captureWord),
    .wordCountDelayed(wordCountDelayed),
    .busRdData(busRdData),
    .lineWrData(lineWrData),
    .lineRdData(lineRdData),
    .wrWord(wrWord)
  );

  busAdapter busAdapter_inst (
    .clk(clk),
    .reset(reset),
    .req(req),
    .lineAdr(lineAdr),
    .selUncachedAdr(selUncachedAdr),
    .busRead(busRead),
    .busWrite(busWrite),
    .selLineWord(selLineWord),
    .trans(trans),
    .burst(burst),
    .wordCount(wordCount),
    .wrWord(wrWord),
    .busRdData(busRdData),
    .busAck(busReady),
    .busCmd(busCmd),
    .busWrData(busWrData),
    .rdData(rdData)
  );

endmodule

//--- bench/memModel.sv
// Bus memory model for the load/store bus testbench.
// Acts as an AHB-Lite style slave with a word memory. Each accepted address
// phase gets the wait-state count present on waitStates, and holdOff pulls
// ready low for as long as it is set.

`timescale 1ns/10ps
`include "lsuBus_params.svh"

module memModel #(
  parameter int Depth = 256
) (
  input  logic clk,
  input  logic reset,
  input  lsuBusPkg::busCmdT busCmd,
  input  lsuBusPkg::wordT busWrData,
  input  logic [1:0] waitStates,
  input  logic holdOff,
  output lsuBusPkg::wordT busRdData,
  output logic busReady
);

  import lsuBusPkg::*;

  localparam int IdxW = $clog2(Depth);

  wordT mem [0:Depth-1];
  logic pendValid;
  logic pendWrite;
  adrT pendAdr;
  logic [1:0] waitLeft;

  // Every word starts from a value that depends on its whole index
  initial begin
    for (int i = 0; i < Depth; i++) begin
      mem[i] = (wordT'(i) * 32'h9e3779b1) ^ 32'h13572468;
    end
  end

  ///////////////////////////////
  // Ready and read data
  ///////////////////////////////
  // Ready only drops while a data phase still has wait states left
  assign busReady = ~holdOff & (waitLeft == 2'd0);

  // Read data is presented for the whole data phase
  assign busRdData = (pendValid & ~pendWrite) ? mem[pendAdr[IdxW+1:2]] : '0;

  ///////////////////////////////
  // Pipeline
  ///////////////////////////////
  always @(posedge clk) begin
    if (reset) begin
      pendValid <= 1'b0;
      pendWrite <= 1'b0;
      pendAdr <= '0;
      waitLeft <= 2'd0;
    end else if (busReady) begin
      // The previous data phase ends and the current address phase is taken
      if (pendValid & pendWrite) begin
        mem[pendAdr[IdxW+1:2]] <= busWrData;
      end
      pendValid <= busCmd.trans[1];
      pendWrite <= busCmd.write;
      pendAdr <= busCmd.adr;
      waitLeft <= busCmd.trans[1] ? waitStates : 2'd0;
    end else if (waitLeft != 2'd0) begin
      waitLeft <= waitLeft - 2'd1;
    end
  end

endmodule

//--- bench/lsuBusTb.sv
// Testbench for the load/store bus interface.
// Runs uncached processor accesses and cache line transfers through the DUT
// against a bus memory model with pseudo-random wait states. A shadow copy of
// the memory supplies every expected value, and a bus monitor logs each
// address phase and write data phase for the tests to inspect.

`timescale 1ns/10ps
`include "lsuBus_params.svh"

module lsuBusTb;

  import lsuBusPkg::*;

  localparam int MemWords = 256;
  localparam int MaxWait = 200;

  logic clk;
  logic reset;
  cpuReqT req;
  logic ignoreRequest;
  logic cpuBusy;
  logic stall;
  logic committed;
  wordT rdData;
  logic fetchLine;
  logic writeLine;
  adrT lineAdr;
  lineT lineWrData;
  lineT lineRdData;
  logic cacheBusAck;
  busCmdT busCmd;
  wordT busWrData;
  wordT busRdData;
  logic busReady;
  logic [1:0] waitStates;
  logic holdOff;
  logic randomWaits;

  wordT shadowMem [0:MemWords-1];
  busCmdT cmdLog [$];
  wordT wrLog [$];
  logic [31:0] lfsrWait;
  logic [31:0] lfsrData;
  int errCount;
  int testErrs;
  int passCount;
  int failCount;
  int ackCount;

  // Monitor state from the previous falling edge
  logic dataIsWrite;
  logic prevLow;
  busCmdT cmdPrev;
  wordT wrDataPrev;
  beatT wcPrev;
  beatT wcdPrev;

  lsuBus lsuBus_inst (.*);

  memModel #(.Depth(MemWords)) memModel_inst (
    .clk(clk),
    .reset(reset),
    .busCmd(busCmd),
    .busWrData(busWrData),
    .waitStates(waitStates),
    .holdOff(holdOff),
    .busRdData(busRdData),
    .busReady(busReady)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ///////////////////////////////
  // Helpers
  ///////////////////////////////
  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic randWord(output wordT w);
    int i;
    for (i = 0; i < `LSU_XLEN; i++) begin
      lfsrData = lfsrNext(lfsrData);
      w[i] = lfsrData[0];
    end
  endtask

  task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("ERR %s got %h expected %h", name, got, exp);
      errCount++;
    end
  endtask

  task automatic checkTrue(input string what, input logic cond);
    assert (cond === 1'b1) else begin
      $display("Check failed: %s", what);
      errCount++;
    end
  endtask

  // Waits for stall, or committed when forCommit is set, to go low
  task automatic waitIdle(input string what, input bit forCommit);
    int n;
    for (n = 0; n < MaxWait; n++) begin
      @(negedge clk);
      if (!(forCommit ? committed : stall)) break;
    end
    if (n == MaxWait) begin
      $display("Timeout after %0d cycles waiting for %s", MaxWait, what);
      errCount++;
    end
  endtask

  task automatic reportTest(input string name);
    if (errCount == testErrs) begin
      passCount++;
      $display("test %s: ok", name);
    end else begin
      failCount++;
      $display("test %s: %0d errors", name, errCount - testErrs);
    end
    testErrs = errCount;
  endtask

  // Runs one single-word access and holds the request until it has left the bus
  task automatic uncachedAccess(input logic doWrite, input adrT adr, input wordT wdata,
                                output wordT data);
    int first;
    int n;
    busCmdT cmd;
    @(posedge clk);
    #1;
    first = cmdLog.size();
    req.readWrite = doWrite ? 2'b01 : 2'b10;
    req.adr = adr;
    req.wdata = wdata;
    req.cacheable = 1'b0;
    // Read data must already be on rdData in the completing cycle
    for (n = 0; n < MaxWait; n++) begin
      @(negedge clk);
      if (lsuBus_inst.transComplete) break;
    end
    if (n == MaxWait) begin
      $display("Timeout after %0d cycles waiting for transComplete", MaxWait);
      errCount++;
    end
    data = rdData;
    waitIdle("uncached access to finish", 1'b0);
    if (!doWrite) begin
      checkValue("rdData held", rdData, data);
    end
    @(posedge clk);
    #1;
    req.readWrite = 2'b00;
    checkValue("address phase count", cmdLog.size() - first, 1);
    if (cmdLog.size() > first) begin
      cmd = cmdLog[first];
      checkValue("busCmd.adr", cmd.adr, adr);
      checkValue("busCmd.trans", cmd.trans, transNonseq);
      checkValue("busCmd.burst", cmd.burst, burstSingle);
      checkValue("busCmd.write", cmd.write, doWrite);
    end
    if (doWrite) begin
      shadowMem[adr[9:2]] = wdata;
      checkValue("busWrData", wrLog[$], wdata);
      checkValue("memory word", memModel_inst.mem[adr[9:2]], wdata);
    end
  endtask

  // Runs a full line fetch or writeback and can stretch it with back-pressure
  task automatic lineTransfer(input logic doWrite, input adrT adr, input lineT line,
                              input bit stretch);
    int first;
    int firstWr;
    int acks;
    int n;
    int i;
    bit held;
    busCmdT cmd;
    @(posedge clk);
    #1;
    first = cmdLog.size();
    firstWr = wrLog.size();
    acks = ackCount;
    held = 1'b0;
    lineAdr = adr;
    lineWrData = line;
    fetchLine = ~doWrite;
    writeLine = doWrite;
    for (n = 0; n < MaxWait; n++) begin
      @(negedge clk);
      if (cacheBusAck) break;
      // Freeze the bus for five cycles once a SEQ beat is going out
      if (stretch && !held && busReady && busCmd.trans == transSeq) begin
        held = 1'b1;
        @(posedge clk);
        #1;
        holdOff = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        holdOff = 1'b0;
      end
    end
    if (n == MaxWait) begin
      $display("Timeout after %0d cycles waiting for cacheBusAck", MaxWait);
      errCount++;
    end
    @(posedge clk);
    #1;
    fetchLine = 1'b0;
    writeLine = 1'b0;
    // One more cycle lets a stray second ack show up in the count
    @(posedge clk);
    #1;
    checkValue("cacheBusAck pulse count", ackCount - acks, 1);
    checkValue("address phase count", cmdLog.size() - first, `LSU_WORDS_PER_LINE);
    for (i = 0; i < `LSU_WORDS_PER_LINE && first + i < cmdLog.size(); i++) begin
      cmd = cmdLog[first + i];
      checkValue("busCmd.adr", cmd.adr, adr + 4 * i);
      checkValue("busCmd.trans", cmd.trans, (i == 0) ? transNonseq : transSeq);
      checkValue("busCmd.burst", cmd.burst, burstIncr4);
      checkValue("busCmd.write", cmd.write, doWrite);
    end
    for (i = 0; i < `LSU_WORDS_PER_LINE; i++) begin
      if (doWrite) begin
        shadowMem[adr[9:2] + i] = line[i*`LSU_XLEN +: `LSU_XLEN];
        if (firstWr + i < wrLog.size()) begin
          checkValue("busWrData", wrLog[firstWr + i], line[i*`LSU_XLEN +: `LSU_XLEN]);
        end
      end else begin
        checkValue("lineRdData word", lineRdData[i*`LSU_XLEN +: `LSU_XLEN],
                   shadowMem[adr[9:2] + i]);
      end
    end
    if (doWrite) begin
      checkValue("write data phase count", wrLog.size() - firstWr, `LSU_WORDS_PER_LINE);
    end
    if (stretch) begin
      checkTrue("bus held low for five cycles during a SEQ beat", held);
    end
  endtask

  ///////////////////////////////
  // Wait states and bus monitor
  ///////////////////////////////
  always @(posedge clk) begin
    #1;
    if (randomWaits) begin
      lfsrWait = lfsrNext(lfsrWait);
      waitStates[0] = lfsrWait[0];
      lfsrWait = lfsrNext(lfsrWait);
      waitStates[1] = lfsrWait[0];
    end else begin
      waitStates = 2'd0;
    end
  end

  // A cycle with ready low must leave the bus outputs and beat counters alone
  always @(negedge clk) begin
    if (reset) begin
      dataIsWrite = 1'b0;
      prevLow = 1'b0;
    end else begin
      if (prevLow) begin
        checkValue("busCmd", busCmd, cmdPrev);
        checkValue("busWrData", busWrData, wrDataPrev);
        checkValue("wordCount", lsuBus_inst.busFsm_inst.wordCount, wcPrev);
        checkValue("wordCountDelayed", lsuBus_inst.busFsm_inst.wordCountDelayed, wcdPrev);
      end
      if (busReady) begin
        if (dataIsWrite) begin
          wrLog.push_back(busWrData);
        end
        if (busCmd.trans[1]) begin
          cmdLog.push_back(busCmd);
        end
        dataIsWrite = busCmd.trans[1] & busCmd.write;
      end
      if (cacheBusAck) begin
        ackCount++;
      end
      prevLow = ~busReady;
      cmdPrev = busCmd;
      wrDataPrev = busWrData;
      wcPrev = lsuBus_inst.busFsm_inst.wordCount;
      wcdPrev = lsuBus_inst.busFsm_inst.wordCountDelayed;
    end
  end

  ///////////////////////////////
  // Test sequence
  ///////////////////////////////
  initial begin
    int first;
    int i;
    wordT w;
    wordT data;
    lineT line;
    reset = 1'b1;
    req = '0;
    ignoreRequest = 1'b0;
    cpuBusy = 1'b0;
    fetchLine = 1'b0;
    writeLine = 1'b0;
    lineAdr = '0;
    lineWrData = '0;
    holdOff = 1'b0;
    randomWaits = 1'b0;
    waitStates = 2'd0;
    lfsrWait = 32'hd0fd;
    lfsrData = 32'hd0fd;
    errCount = 0;
    passCount = 0;
    failCount = 0;
    ackCount = 0;
    for (i = 0; i < MemWords; i++) begin
      shadowMem[i] = (wordT'(i) * 32'h9e3779b1) ^ 32'h13572468;
    end
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    testErrs = errCount;

    // Idle outputs after reset, then requests that must be ignored
    @(negedge clk);
    checkValue("stall", stall, 0);
    checkValue("committed", committed, 0);
    checkValue("cacheBusAck", cacheBusAck, 0);
    checkValue("busCmd.trans", busCmd.trans, transIdle);
    checkValue("busCmd.write", busCmd.write, 0);
    @(posedge clk);
    #1;
    first = cmdLog.size();
    ignoreRequest = 1'b1;
    req.readWrite = 2'b10;
    req.adr = 32'h40;
    fetchLine = 1'b1;
    lineAdr = 32'h100;
    repeat (8) begin
      @(negedge clk);
      checkValue("stall", stall, 0);
      checkValue("committed", committed, 0);
    end
    @(posedge clk);
    #1;
    req.readWrite = 2'b00;
    fetchLine = 1'b0;
    ignoreRequest = 1'b0;
    checkValue("address phases while ignored", cmdLog.size() - first, 0);
    reportTest("reset and ignored requests");

    randomWaits = 1'b1;
    uncachedAccess(1'b0, 32'h40, '0, data);
    checkValue("rdData", data, shadowMem[8'h10]);
    uncachedAccess(1'b0, 32'h3fc, '0, data);
    checkValue("rdData", data, shadowMem[8'hff]);
    reportTest("uncached read");

    // Write while the processor stays busy, then read the word back
    randWord(w);
    cpuBusy = 1'b1;
    uncachedAccess(1'b1, 32'h84, w, data);
    repeat (5) begin
      @(negedge clk);
      checkTrue("committed held while cpuBusy is high", committed);
    end
    @(posedge clk);
    #1;
    cpuBusy = 1'b0;
    waitIdle("committed to drop", 1'b1);
    uncachedAccess(1'b0, 32'h84, '0, data);
    checkValue("rdData", data, w);
    reportTest("uncached write");

    lineTransfer(1'b0, 32'h100, '0, 1'b0);
    reportTest("line fetch");

    for (i = 0; i < `LSU_WORDS_PER_LINE; i++) begin
      randWord(line[i*`LSU_XLEN +: `LSU_XLEN]);
    end
    lineTransfer(1'b1, 32'h200, line, 1'b0);
    lineTransfer(1'b0, 32'h200, '0, 1'b0);
    checkValue("lineRdData", lineRdData, line);
    reportTest("line writeback");

    for (i = 0; i < `LSU_WORDS_PER_LINE; i++) begin
      randWord(line[i*`LSU_XLEN +: `LSU_XLEN]);
    end
    lineTransfer(1'b1, 32'h300, line, 1'b1);
    lineTransfer(1'b0, 32'h300, '0, 1'b1);
    reportTest("back-pressure");

    $display("tests passed %0d failed %0d", passCount, failCount);
    if (errCount == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- lsuBus.f
+incdir+hw
hw/lsuBusPkg.sv
hw/busFsm.sv
hw/lineBuffer.sv
hw/busAdapter.sv
hw/lsuBus.sv
bench/memModel.sv
bench/lsuBusTb.sv

//--- Bender.yml
package:
  name: lsuBus

sources:
  - include_dirs:
      - hw
    files:
      - hw/lsuBusPkg.sv
      - hw/busFsm.sv
      - hw/lineBuffer.sv
      - hw/busAdapter.sv
      - hw/lsuBus.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/memModel.sv
      - bench/lsuBusTb.sv
